//--- source/muldiv_defines.svh
// multiply/divide unit width definitions
// operand width and iteration counter width, shared by all blocks

`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// --------------------
// operand width
// --------------------

// one operand, one quotient, one remainder, one product half
`define MULDIV_XLEN 32

// --------------------
// iteration counter
// --------------------

// counts XLEN steps down to zero, so log2(XLEN) bits
`define MULDIV_CNT_W 5

`endif

//--- source/muldiv_pkg.sv
// multiply/divide unit types
// function codes and the 64-bit result word in its two readings

`default_nettype none

`include "muldiv_defines.svh"

package muldiv_pkg;

  // --------------------
  // function codes
  // --------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,  // signed multiply
    fn_mulu = 2'd1,  // unsigned multiply
    fn_div  = 2'd2,  // signed divide
    fn_divu = 2'd3   // unsigned divide
  } muldiv_fn_t;

  // --------------------
  // result word
  // --------------------

  // full product, high half on top
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] hi;
    logic [`MULDIV_XLEN-1:0] lo;
  } mul_result_s;

  // remainder on top, quotient below
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] rem;
    logic [`MULDIV_XLEN-1:0] quo;
  } div_result_s;

  // same 64 bits, decoded by the function that made them
  typedef union packed {
    mul_result_s mul;
    div_result_s div;
  } muldiv_result_u;

endpackage

`default_nettype wire

//--- source/muldiv_op_if.sv
// operation channel between multiply/divide blocks
// valid/ready transfer of two magnitudes plus sign flags

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

interface muldiv_op_if;

  // handshake
  logic val;
  logic rdy;

  // operation kind, divide when set
  logic is_div;

  // unsigned magnitudes
  // on the core output these carry the upper and lower result halves
  logic [`MULDIV_XLEN-1:0] mag_a;
  logic [`MULDIV_XLEN-1:0] mag_b;

  // negate product or quotient
  logic neg_main;
  // negate remainder
  logic neg_rem;

  // producer side
  modport source (
    output val, output is_div, output mag_a, output mag_b,
    output neg_main, output neg_rem,
    input  rdy
  );

  // consumer side
  modport sink (
    input  val, input is_div, input mag_a, input mag_b,
    input  neg_main, input neg_rem,
    output rdy
  );

endinterface

`default_nettype wire

//--- source/muldiv_operand_unit.sv
// multiply/divide operand stage
// takes one request, turns the operands into magnitudes and sign flags

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_operand_unit import muldiv_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  muldiv_fn_t              req_fn,
  input  logic [`MULDIV_XLEN-1:0] req_a,
  input  logic [`MULDIV_XLEN-1:0] req_b,
  muldiv_op_if.source             op
);

  logic                    full;
  logic                    accept;
  logic                    is_signed;
  logic                    is_div;
  logic                    sign_a;
  logic                    sign_b;
  logic                    b_zero;
  logic [`MULDIV_XLEN-1:0] mag_a_reg;
  logic [`MULDIV_XLEN-1:0] mag_b_reg;
  logic                    is_div_reg;
  logic                    neg_main_reg;
  logic                    neg_rem_reg;

  // --------------------
  // request decode
  // --------------------

  assign is_signed = (req_fn == fn_mul) || (req_fn == fn_div);
  assign is_div    = (req_fn == fn_div) || (req_fn == fn_divu);

  // sign bits only count for the signed functions
  assign sign_a = is_signed && req_a[`MULDIV_XLEN-1];
  assign sign_b = is_signed && req_b[`MULDIV_XLEN-1];
  assign b_zero = (req_b == '0);

  // slot frees on the core transfer, so a full slot can still refill
  assign req_rdy = !full || op.rdy;
  assign accept  = req_val && req_rdy;

  // --------------------
  // slot
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (op.val && op.rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      // two's complement negation of negative operands
      mag_a_reg    <= sign_a ? (~req_a + 1'b1) : req_a;
      mag_b_reg    <= sign_b ? (~req_b + 1'b1) : req_b;
      is_div_reg   <= is_div;
      // divide by zero keeps the all-ones quotient unsigned
      neg_main_reg <= (sign_a ^ sign_b) && !(is_div && b_zero);
      // remainder follows the dividend
      neg_rem_reg  <= is_div && sign_a;
    end
  end

  assign op.val      = full;
  assign op.is_div   = is_div_reg;
  assign op.mag_a    = mag_a_reg;
  assign op.mag_b    = mag_b_reg;
  assign op.neg_main = neg_main_reg;
  assign op.neg_rem  = neg_rem_reg;

endmodule

`default_nettype wire

//--- source/muldiv_iter_core.sv
// multiply/divide iterative core
// one bit per cycle, shift-add multiply or restoring divide on magnitudes

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_iter_core import muldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  muldiv_op_if.sink   op,
  muldiv_op_if.source res
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]                state;
  logic [`MULDIV_CNT_W-1:0]  count;
  logic                      op_fire;
  logic                      res_fire;
  logic                      last_step;

  // multiplicand, shifted left each step
  logic [2*`MULDIV_XLEN-1:0] a_reg;
  // multiplier shifted right, or the fixed divisor
  logic [`MULDIV_XLEN-1:0]   b_reg;
  // product accumulator, or remainder:quotient shift register
  muldiv_result_u            acc;

  logic                      is_div_reg;
  logic                      neg_main_reg;
  logic                      neg_rem_reg;

  // divider trial subtraction
  logic [`MULDIV_XLEN:0]     rem_shift;
  logic [`MULDIV_XLEN+1:0]   trial;

  assign op_fire   = op.val && op.rdy;
  assign res_fire  = res.val && res.rdy;
  assign last_step = (count == '0);

  // next dividend bit moves into the partial remainder
  assign rem_shift = {acc.div.rem, acc.div.quo[`MULDIV_XLEN-1]};
  // extra top bit is the borrow
  assign trial     = {1'b0, rem_shift} - {2'b00, b_reg};

  // --------------------
  // control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (op_fire) begin
            state <= st_calc;
            // XLEN steps, counting down to zero
            count <= `MULDIV_CNT_W'(`MULDIV_XLEN - 1);
          end
        end
        st_calc: begin
          count <= count - 1'b1;
          // this edge is the last step
          if (last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (res_fire) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (op_fire) begin
      a_reg        <= {{`MULDIV_XLEN{1'b0}}, op.mag_a};
      b_reg        <= op.mag_b;
      // divide starts with a zero remainder and the dividend below it
      acc          <= op.is_div ? {{`MULDIV_XLEN{1'b0}}, op.mag_a} : '0;
      is_div_reg   <= op.is_div;
      neg_main_reg <= op.neg_main;
      neg_rem_reg  <= op.neg_rem;
    end else if (state == st_calc) begin
      if (is_div_reg) begin
        if (!trial[`MULDIV_XLEN+1]) begin
          // divisor fits, keep the difference and set the quotient bit
          acc.div.rem <= trial[`MULDIV_XLEN-1:0];
          acc.div.quo <= {acc.div.quo[`MULDIV_XLEN-2:0], 1'b1};
        end else begin
          // restore, the remainder is just shifted
          acc.div.rem <= rem_shift[`MULDIV_XLEN-1:0];
          acc.div.quo <= {acc.div.quo[`MULDIV_XLEN-2:0], 1'b0};
        end
      end else begin
        // add the multiplicand where the multiplier bit is one
        if (b_reg[0]) begin
          acc <= acc + a_reg;
        end
        a_reg <= a_reg << 1;
        b_reg <= b_reg >> 1;
      end
    end
  end

  // --------------------
  // handshakes
  // --------------------

  assign op.rdy = (state == st_idle);

  // upper half is hi or rem, lower half lo or quo
  assign res.val      = (state == st_done);
  assign res.is_div   = is_div_reg;
  assign res.mag_a    = acc.mul.hi;
  assign res.mag_b    = acc.mul.lo;
  assign res.neg_main = neg_main_reg;
  assign res.neg_rem  = neg_rem_reg;

endmodule

`default_nettype wire

//--- source/muldiv_result_unit.sv
// multiply/divide result stage
// applies sign correction and holds the response until it is taken

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_result_unit import muldiv_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  muldiv_op_if.sink                 res,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output logic [2*`MULDIV_XLEN-1:0] resp_result
);

  muldiv_result_u raw_word;
  muldiv_result_u fixed_word;
  logic           res_fire;

  // core result as one word
  assign raw_word = {res.mag_a, res.mag_b};

  // free when empty or when the held word leaves this cycle
  assign res.rdy  = !resp_val || resp_rdy;
  assign res_fire = res.val && res.rdy;

  // --------------------
  // sign correction
  // --------------------

  always_comb begin
    fixed_word = raw_word;
    if (res.is_div) begin
      // quotient and remainder fix up independently
      if (res.neg_main) begin
        fixed_word.div.quo = ~raw_word.div.quo + 1'b1;
      end
      if (res.neg_rem) begin
        fixed_word.div.rem = ~raw_word.div.rem + 1'b1;
      end
    end else if (res.neg_main) begin
      // product negates across both halves
      fixed_word = ~raw_word + 1'b1;
    end
  end

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (res_fire) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // word only changes when a new one comes in
  always_ff @(posedge clk) begin
    if (res_fire) begin
      resp_result <= fixed_word;
    end
  end

endmodule

`default_nettype wire

//--- source/muldiv_unit.sv
// 32-bit iterative multiply/divide unit
// operand stage, shared iterative core and result stage in a chain

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_unit import muldiv_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  // request
  input  logic                      req_val,
  output logic                      req_rdy,
  input  muldiv_fn_t                req_fn,
  input  logic [`MULDIV_XLEN-1:0]   req_a,
  input  logic [`MULDIV_XLEN-1:0]   req_b,
  // response
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output logic [2*`MULDIV_XLEN-1:0] resp_result
);

  // operand stage to core
  muldiv_op_if op_bus ();
  // core to result stage
  muldiv_op_if res_bus ();

  muldiv_operand_unit u_operand (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .op      (op_bus.source)
  );

  muldiv_iter_core u_core (
    .clk   (clk),
    .reset (reset),
    .op    (op_bus.sink),
    .res   (res_bus.source)
  );

  muldiv_result_unit u_result (
    .clk         (clk),
    .reset       (reset),
    .res         (res_bus.sink),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

//--- verification/muldiv_clk_gen.sv
// testbench clock and reset for the multiply/divide unit
// 100 ns clock, reset high for the first 16 rising edges

`timescale 1ns/1ps
`default_nettype none

module muldiv_clk_gen (
  output logic clk,
  output logic reset
);

  localparam int reset_cycles = 16;

  // half of the 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // released on a falling edge, like all other stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/muldiv_asserts.sv
// handshake and latency checks bound to the multiply/divide unit
// tracks accepted requests to tell an idle unit from a busy one

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_asserts (
  input logic                      clk,
  input logic                      reset,
  input logic                      req_val,
  input logic                      req_rdy,
  input logic                      resp_val,
  input logic                      resp_rdy,
  input logic [2*`MULDIV_XLEN-1:0] resp_result
);

  logic        req_fire;
  logic        resp_fire;
  logic [2:0]  in_flight;
  // number of failed checks so far
  int unsigned fail_count = 0;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // requests accepted and not yet answered
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 3'(req_fire) - 3'(resp_fire);
    end
  end

  // --------------------
  // response channel
  // --------------------

  // a waiting response keeps valid and word until taken
  resp_held: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      $error("response dropped or changed before its transfer");
      fail_count = fail_count + 1;
    end

  // every response needs an accepted request behind it
  resp_owed: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> in_flight != '0)
    else begin
      $error("response without an outstanding request");
      fail_count = fail_count + 1;
    end

  // operand slot, core and result stage hold one each
  depth_cap: assert property (@(posedge clk) disable iff (reset)
    in_flight <= 3'd3)
    else begin
      $error("more than three operations in flight");
      fail_count = fail_count + 1;
    end

  // --------------------
  // latency
  // --------------------

  // resp_val is set on the 34th edge after the accept,
  // so it is first sampled high one edge later
  idle_latency: assert property (@(posedge clk) disable iff (reset)
    req_fire && in_flight == '0 |-> ##35 $rose(resp_val))
    else begin
      $error("isolated request not answered after 34 cycles");
      fail_count = fail_count + 1;
    end

endmodule

bind muldiv_unit muldiv_asserts u_asserts (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

//--- verification/muldiv_tb.sv
// testbench top for the multiply/divide unit
// corner cases, back-to-back and back-pressured random requests vs a reference model

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_tb import muldiv_pkg::*; ();

  localparam int reset_cycles    = 16;
  localparam int n_directed      = 8;
  localparam int n_random        = 40;
  localparam int n_tests         = n_directed + 2 * n_random;
  localparam int cycles_per_test = 40;

  logic                      clk;
  logic                      reset;
  logic                      req_val;
  logic                      req_rdy;
  muldiv_fn_t                req_fn;
  logic [`MULDIV_XLEN-1:0]   req_a;
  logic [`MULDIV_XLEN-1:0]   req_b;
  logic                      resp_val;
  logic                      resp_rdy = 1'b1;
  logic [2*`MULDIV_XLEN-1:0] resp_result;

  // expected words in request order
  logic [63:0] exp_q[$];
  logic        bp_on = 1'b0;
  // operand stream and back-pressure stream
  logic [31:0] lfsr_state = 32'd47;
  logic [31:0] bp_state = 32'd47;

  muldiv_clk_gen u_clk (.clk(clk), .reset(reset));

  muldiv_unit u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // --------------------
  // helpers
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit, newest bit at the bottom
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // product as hi:lo, division as rem:quo
  function automatic logic [63:0] ref_result(input muldiv_fn_t fn,
                                             input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [31:0]        quo;
    logic [31:0]        rem;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == fn_mul) begin
      return sa * sb;
    end else if (fn == fn_mulu) begin
      return {32'b0, a} * {32'b0, b};
    end
    if (b == '0) begin
      // divide by zero
      quo = '1;
      rem = a;
    end else if (fn == fn_div && a == 32'h8000_0000 && b == '1) begin
      // overflow case
      quo = a;
      rem = '0;
    end else if (fn == fn_div) begin
      // truncating division with the remainder taking the dividend sign
      quo = 32'(sa / sb);
      rem = 32'(sa % sb);
    end else begin
      quo = a / b;
      rem = a % b;
    end
    return {rem, quo};
  endfunction

  // req_rdy does not depend on req_val and is steady at the falling edge
  task automatic send_req(input muldiv_fn_t fn, input logic [31:0] a, input logic [31:0] b);
    logic taken;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    taken   = 1'b0;
    while (!taken) begin
      taken = req_rdy;
      @(negedge clk);
    end
    exp_q.push_back(ref_result(fn, a, b));
    req_val = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || resp_val) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic run_isolated(input muldiv_fn_t fn, input logic [31:0] a, input logic [31:0] b);
    send_req(fn, a, b);
    wait_idle();
  endtask

  task automatic send_random();
    logic [31:0] fn_bits;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] mode;
    take_bits(2, fn_bits);
    take_bits(32, a);
    take_bits(2, mode);
    if (mode == 32'd2) begin
      // small signed divisor for wide quotients
      take_bits(5, b);
      b = {{27{b[4]}}, b[4:0]};
    end else begin
      take_bits(32, b);
    end
    send_req(muldiv_fn_t'(fn_bits[1:0]), a, b);
  endtask

  // --------------------
  // response side
  // --------------------

  // owns resp_rdy and checks each word before the edge that takes it
  always @(negedge clk) begin : resp_side
    logic [63:0] exp_word;
    if (!reset) begin
      if (bp_on) begin
        bp_state = lfsr_step(bp_state);
        resp_rdy = bp_state[0];
      end else begin
        resp_rdy = 1'b1;
      end
      if (resp_val && resp_rdy) begin
        assert (exp_q.size() != 0)
          else abort_run("a response arrived with no request outstanding");
        exp_word = exp_q.pop_front();
        assert (resp_result === exp_word)
          else abort_run($sformatf("Error: time %0t resp_result got %h expected %h",
                                   $time, resp_result, exp_word));
      end
    end
  end

  // bound checks raise their count and the run stops on the next falling edge
  always @(negedge clk) begin
    if (u_dut.u_asserts.fail_count != 0) begin
      abort_run("a bound handshake or latency check failed");
    end
  end

  initial begin
    repeat (reset_cycles + n_tests * cycles_per_test) @(posedge clk);
    abort_run("no response arrived in time, watchdog expired");
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin
    req_val = 1'b0;
    req_fn  = fn_mul;
    req_a   = '0;
    req_b   = '0;
    @(negedge reset);
    @(negedge clk);
    assert (req_rdy === 1'b1)
      else abort_run($sformatf("Error: time %0t req_rdy got %b expected 1", $time, req_rdy));
    assert (resp_val === 1'b0)
      else abort_run($sformatf("Error: time %0t resp_val got %b expected 0", $time, resp_val));

    // isolated corner cases each timed by the latency check
    run_isolated(fn_mul, 32'hFFFF_FFF9, 32'd3);
    run_isolated(fn_mulu, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    run_isolated(fn_mul, 32'h8000_0000, 32'h8000_0000);
    run_isolated(fn_divu, 32'd100, 32'd0);
    run_isolated(fn_div, 32'hFFFF_FF9C, 32'd0);
    run_isolated(fn_div, 32'h8000_0000, 32'hFFFF_FFFF);
    run_isolated(fn_div, 32'hFFFF_FFEF, 32'd5);
    run_isolated(fn_divu, 32'hFFFF_FFFF, 32'd7);

    // back-to-back with resp_rdy high
    repeat (n_random) send_random();
    wait_idle();

    // random back-pressure fills all three stages
    @(posedge clk);
    bp_on = 1'b1;
    @(negedge clk);
    repeat (n_random) send_random();
    wait_idle();

    if (u_dut.u_asserts.fail_count != 0) begin
      abort_run("a bound handshake or latency check failed");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/muldiv_pkg.sv
source/muldiv_op_if.sv
source/muldiv_operand_unit.sv
source/muldiv_iter_core.sv
source/muldiv_result_unit.sv
source/muldiv_unit.sv
verification/muldiv_clk_gen.sv
verification/muldiv_asserts.sv
verification/muldiv_tb.sv
